/* mmu.f */
hdl/mmu_pkg.sv
hdl/mmu_tlb.sv
hdl/mmu_walk_ctrl.sv
hdl/mmu_mem_port.sv
hdl/mmu_top.sv
verification/mmu_properties.sv
verification/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - hdl/mmu_pkg.sv
  - hdl/mmu_tlb.sv
  - hdl/mmu_walk_ctrl.sv
  - hdl/mmu_mem_port.sv
  - hdl/mmu_top.sv
  - target: simulation
    files:
      - verification/mmu_properties.sv
      - verification/mmu_tb.sv

/* verification/mmu_tb.sv */
module mmu_tb;
	import mmu_pkg::*;

	timeunit 1ns;
	timeprecision 1ps;

	localparam word_t L1_PDT = 32'h0010_0000;
	localparam word_t L2_PDT = 32'h0020_0000;
	localparam word_t L1_ADDR = 32'h0004_3ABC;
	localparam word_t L2_ADDR = 32'h0C85_6DEF;
	localparam int WAIT_LIMIT = 200;

	logic iCLOCK;
	logic inRESET;
	logic tlb_flush;
	logic logic_req;
	logic_cmd_t logic_cmd;
	logic mem_lock;
	logic mem_valid;
	word_t mem_rdata;
	logic logic_lock;
	logic mem_req;
	mem_cmd_t mem_cmd;
	logic flags_req;
	mmu_flags_t flags;

	// Memory model state
	word_t table_mem [word_t];
	word_t table_reads [$];
	mem_cmd_t accesses [$];
	mmu_flags_t access_flags [$];
	logic access_flagged [$];
	logic resp_busy;
	logic [15:0] resp_wait;
	word_t resp_data;
	logic [15:0] lock_draw;
	logic lock_random;

	logic [15:0] lfsr_state = 16'd97;
	int errors;
	int checks;
	int tests_run;

	mmu_top i_mmu_top (.*);

	always #20 iCLOCK = ~iCLOCK;

	function automatic logic [15:0] galois_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] take_bits(input int count);
		logic [15:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = galois_step(lfsr_state);
			bits = {bits[14:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	// Unwritten locations hold a pattern of their whole address
	function automatic word_t read_entry(input word_t addr);
		if (table_mem.exists(addr)) begin
			return table_mem[addr];
		end
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_3C3C;
	endfunction

	function automatic mmu_mode_e pick_mode(input logic [1:0] bits);
		case (bits)
			2'd0: return PAGING_OFF;
			2'd1: return PAGING_LEVEL_1;
			default: return PAGING_LEVEL_2;
		endcase
	endfunction

	function automatic logic_cmd_t make_cmd(input mmu_mode_e mode, input word_t addr);
		logic_cmd_t cmd;
		cmd = '0;
		cmd.mode = mode;
		cmd.addr = addr;
		cmd.pdt = (mode == PAGING_LEVEL_2) ? L2_PDT : L1_PDT;
		cmd.order = 2'd2;
		cmd.mask = 4'hF;
		cmd.data = ~addr;
		return cmd;
	endfunction

	// Memory model takes accesses and answers table reads after a random delay
	always @(posedge iCLOCK) begin
		mem_valid <= 1'b0;
		if (resp_busy) begin
			if (resp_wait == 0) begin
				mem_valid <= 1'b1;
				mem_rdata <= resp_data;
				resp_busy = 1'b0;
			end else begin
				resp_wait = resp_wait - 1;
			end
		end
		if (inRESET && mem_req && !mem_lock) begin
			if (mem_cmd.mmu_use) begin
				table_reads.push_back(mem_cmd.addr);
				resp_busy = 1'b1;
				resp_wait = take_bits(2);
				resp_data = read_entry(mem_cmd.addr);
			end else begin
				accesses.push_back(mem_cmd);
				access_flags.push_back(flags);
				access_flagged.push_back(flags_req);
			end
		end
		lock_draw = take_bits(2);
		mem_lock <= lock_random && (lock_draw == 0);
	end

	task automatic abort_run(input string what);
		$display("Timeout while waiting for %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s passed", name);
		end else begin
			$display("%s failed with %0d mismatches", name, errors - errors_before);
		end
	endtask

	// Expected translation from the table rules
	task automatic translate(input logic_cmd_t cmd, output word_t paddr,
			output mmu_flags_t flg, output word_t rd0, output word_t rd1, output int nrd);
		word_t pde;
		word_t pte;
		paddr = cmd.addr;
		flg = '0;
		rd0 = '0;
		rd1 = '0;
		nrd = 0;
		pte = '0;
		if (cmd.mode == PAGING_LEVEL_1) begin
			rd0 = cmd.pdt + 32'd4 * cmd.addr[31:12];
			pte = read_entry(rd0);
			nrd = 1;
		end else if (cmd.mode == PAGING_LEVEL_2) begin
			rd0 = cmd.pdt + 32'd4 * cmd.addr[31:22];
			pde = read_entry(rd0);
			rd1 = {pde[31:12], 12'h000} + 32'd4 * cmd.addr[21:12];
			pte = read_entry(rd1);
			flg.dir = pde[11:0];
			nrd = 2;
		end
		if (nrd > 0) begin
			paddr = {pte[31:12], cmd.addr[11:0]};
			flg.page = pte[11:0];
		end
	endtask

	task automatic issue(input logic_cmd_t cmd);
		int waited;
		waited = 0;
		@(posedge iCLOCK);
		logic_req <= 1'b1;
		logic_cmd <= cmd;
		@(posedge iCLOCK);
		while (logic_lock && waited < WAIT_LIMIT) begin
			@(posedge iCLOCK);
			waited++;
		end
		if (logic_lock) begin
			abort_run("the request to be accepted");
		end else begin
			logic_req <= 1'b0;
		end
	endtask

	task automatic wait_accesses(input int count);
		int waited;
		waited = 0;
		while (accesses.size() < count && waited < WAIT_LIMIT * 8) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (accesses.size() < count) begin
			abort_run("a data access from the MMU");
		end
	endtask

	task automatic check_access(input string name, input logic_cmd_t cmd, input int idx,
			input word_t paddr, input mmu_flags_t flg);
		check(name, paddr, accesses[idx].addr);
		check(name, 1'b0, accesses[idx].mmu_use);
		check(name, cmd.rw, accesses[idx].rw);
		check(name, cmd.mask, accesses[idx].mask);
		check(name, cmd.order, accesses[idx].order);
		check(name, cmd.data, accesses[idx].data);
		check(name, cmd.data_store_ack, accesses[idx].data_store_ack);
		check(name, cmd.mode != PAGING_OFF, access_flagged[idx]);
		if (cmd.mode != PAGING_OFF) begin
			check(name, flg, access_flags[idx]);
		end
	endtask

	// One request with or without the table reads of a walk
	task automatic run_access(input string name, input logic_cmd_t cmd, input bit walks);
		word_t paddr;
		word_t rd0;
		word_t rd1;
		mmu_flags_t flg;
		int nrd;
		int reads_before;
		int idx;
		translate(cmd, paddr, flg, rd0, rd1, nrd);
		if (!walks) begin
			nrd = 0;
		end
		reads_before = table_reads.size();
		idx = accesses.size();
		issue(cmd);
		wait_accesses(idx + 1);
		check(name, nrd, table_reads.size() - reads_before);
		if (nrd > 0 && table_reads.size() > reads_before) begin
			check(name, rd0, table_reads[reads_before]);
		end
		if (nrd > 1 && table_reads.size() > reads_before + 1) begin
			check(name, rd1, table_reads[reads_before + 1]);
		end
		check_access(name, cmd, idx, paddr, flg);
	endtask

	task automatic test_paging_off();
		logic_cmd_t cmd;
		int start;
		start = errors;
		cmd = make_cmd(PAGING_OFF, 32'h1234_5678);
		cmd.rw = 1'b1;
		cmd.mask = 4'b0101;
		cmd.order = 2'd1;
		cmd.data_store_ack = 1'b1;
		cmd.data = 32'hDEAD_BEEF;
		run_access("paging_off", cmd, 1'b1);
		end_test("paging_off", start);
	endtask

	task automatic test_level1_miss();
		int start;
		start = errors;
		run_access("level1_miss", make_cmd(PAGING_LEVEL_1, L1_ADDR), 1'b1);
		end_test("level1_miss", start);
	endtask

	task automatic test_level2_miss();
		int start;
		start = errors;
		run_access("level2_miss", make_cmd(PAGING_LEVEL_2, L2_ADDR), 1'b1);
		end_test("level2_miss", start);
	endtask

	// Same pages at other offsets hit without a walk
	task automatic test_tlb_hit();
		int start;
		start = errors;
		run_access("tlb_hit", make_cmd(PAGING_LEVEL_1, L1_ADDR ^ 32'h0000_0F0C), 1'b0);
		run_access("tlb_hit", make_cmd(PAGING_LEVEL_2, L2_ADDR ^ 32'h0000_0A04), 1'b0);
		end_test("tlb_hit", start);
	endtask

	task automatic test_flush();
		int start;
		start = errors;
		@(posedge iCLOCK);
		tlb_flush <= 1'b1;
		@(posedge iCLOCK);
		tlb_flush <= 1'b0;
		run_access("flush", make_cmd(PAGING_LEVEL_2, L2_ADDR), 1'b1);
		run_access("flush", make_cmd(PAGING_LEVEL_1, L1_ADDR), 1'b1);
		end_test("flush", start);
	endtask

	task automatic test_back_pressure();
		logic_cmd_t cmd;
		logic_cmd_t sent [$];
		word_t paddr;
		word_t rd0;
		word_t rd1;
		mmu_flags_t flg;
		int nrd;
		int base;
		int start;
		start = errors;
		base = accesses.size();
		lock_random = 1'b1;
		for (int i = 0; i < 16; i++) begin
			// Draw at the falling edge away from the memory model
			@(negedge iCLOCK);
			cmd = make_cmd(pick_mode(2'(take_bits(2))),
				{20'h00040 + 20'(take_bits(4)), 12'(take_bits(12))});
			cmd.rw = 1'(take_bits(1));
			sent.push_back(cmd);
			issue(cmd);
		end
		wait_accesses(base + sent.size());
		lock_random = 1'b0;
		check("back_pressure", sent.size(), accesses.size() - base);
		foreach (sent[i]) begin
			translate(sent[i], paddr, flg, rd0, rd1, nrd);
			check_access("back_pressure", sent[i], base + i, paddr, flg);
		end
		end_test("back_pressure", start);
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		tlb_flush = 1'b0;
		logic_req = 1'b0;
		logic_cmd = '0;
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_rdata = '0;
		resp_busy = 1'b0;
		resp_wait = '0;
		resp_data = '0;
		lock_random = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		table_mem[L1_PDT + 32'd4 * L1_ADDR[31:12]] = 32'h8123_40A7;
		table_mem[L2_PDT + 32'd4 * L2_ADDR[31:22]] = 32'h0030_0123;
		table_mem[32'h0030_0000 + 32'd4 * L2_ADDR[21:12]] = 32'h9ABC_D0F5;
		repeat (4) @(posedge iCLOCK);
		inRESET <= 1'b1;
		test_paging_off();
		test_level1_miss();
		test_level2_miss();
		test_tlb_hit();
		test_flush();
		test_back_pressure();
		repeat (2) @(posedge iCLOCK);
		errors = errors + i_mmu_top.i_mmu_properties.assert_failures;
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* verification/mmu_properties.sv */
module mmu_properties
	import mmu_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic logic_req,
	input logic_cmd_t logic_cmd,
	input logic logic_lock,
	input logic mem_req,
	input logic mem_lock,
	input mem_cmd_t mem_cmd,
	input logic flags_req
);

	timeunit 1ns;
	timeprecision 1ps;

	int assert_failures = 0;
	mmu_mode_e accepted_mode;

	// Mode of the request last taken at the logical port
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			accepted_mode <= PAGING_OFF;
		end else if (logic_req && !logic_lock) begin
			accepted_mode <= logic_cmd.mode;
		end
	end

	// A locked access stays on the bus unchanged
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req && mem_lock |=> mem_req && $stable(mem_cmd))
	else begin
		assert_failures++;
		$error("mem_cmd changed while the access was locked");
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		flags_req |-> accepted_mode != PAGING_OFF)
	else begin
		assert_failures++;
		$error("flags_req high in paging-off mode");
	end

	assert property (@(posedge iCLOCK) $rose(inRESET) |-> !logic_lock)
	else begin
		assert_failures++;
		$error("logic_lock high after reset");
	end

endmodule

bind mmu_top mmu_properties i_mmu_properties (.*);

/* hdl/mmu_top.sv */
module mmu_top
	import mmu_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic tlb_flush,
	input logic logic_req,
	input logic_cmd_t logic_cmd,
	input logic mem_lock,
	input logic mem_valid,
	input word_t mem_rdata,
	output logic logic_lock,
	output logic mem_req,
	output mem_cmd_t mem_cmd,
	output logic flags_req,
	output mmu_flags_t flags
);

	// Request port to TLB
	logic tlb_lookup;
	vpn_t tlb_vpn;
	logic tlb_hit;
	vpn_t tlb_frame;
	mmu_flags_t tlb_flags;

	// Request port to walk engine
	logic_cmd_t held_cmd;
	logic walk_start;
	logic walk_table_req;
	word_t walk_table_addr;
	logic walk_access;
	word_t walk_paddr;
	mmu_flags_t walk_flags;

	// Refill path
	logic tlb_refill;
	vpn_t tlb_refill_frame;
	mmu_flags_t tlb_refill_flags;

	mmu_mem_port u_mem_port (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.logic_req(logic_req),
		.logic_cmd(logic_cmd),
		.mem_lock(mem_lock),
		.tlb_hit(tlb_hit),
		.tlb_frame(tlb_frame),
		.tlb_flags(tlb_flags),
		.walk_table_req(walk_table_req),
		.walk_table_addr(walk_table_addr),
		.walk_access(walk_access),
		.walk_paddr(walk_paddr),
		.walk_flags(walk_flags),
		.logic_lock(logic_lock),
		.tlb_lookup(tlb_lookup),
		.tlb_vpn(tlb_vpn),
		.held_cmd(held_cmd),
		.walk_start(walk_start),
		.mem_req(mem_req),
		.mem_cmd(mem_cmd),
		.flags_req(flags_req),
		.flags(flags)
	);

	mmu_tlb u_tlb (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(tlb_flush),
		.lookup(tlb_lookup),
		.lookup_vpn(tlb_vpn),
		.lookup_mode(logic_cmd.mode),
		.refill(tlb_refill),
		.refill_vpn(page_number(held_cmd.addr)),
		.refill_mode(held_cmd.mode),
		.refill_frame(tlb_refill_frame),
		.refill_flags(tlb_refill_flags),
		.hit(tlb_hit),
		.frame(tlb_frame),
		.flags(tlb_flags)
	);

	mmu_walk_ctrl u_walk_ctrl (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.walk_start(walk_start),
		.held_cmd(held_cmd),
		.mem_lock(mem_lock),
		.mem_valid(mem_valid),
		.mem_rdata(mem_rdata),
		.walk_table_req(walk_table_req),
		.walk_table_addr(walk_table_addr),
		.walk_access(walk_access),
		.walk_paddr(walk_paddr),
		.walk_flags(walk_flags),
		.tlb_refill(tlb_refill),
		.tlb_refill_frame(tlb_refill_frame),
		.tlb_refill_flags(tlb_refill_flags)
	);

endmodule

/* hdl/mmu_mem_port.sv */
module mmu_mem_port
	import mmu_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic logic_req,
	input logic_cmd_t logic_cmd,
	input logic mem_lock,
	input logic tlb_hit,
	input vpn_t tlb_frame,
	input mmu_flags_t tlb_flags,
	input logic walk_table_req,
	input word_t walk_table_addr,
	input logic walk_access,
	input word_t walk_paddr,
	input mmu_flags_t walk_flags,
	output logic logic_lock,
	output logic tlb_lookup,
	output vpn_t tlb_vpn,
	output logic_cmd_t held_cmd,
	output logic walk_start,
	output logic mem_req,
	output mem_cmd_t mem_cmd,
	output logic flags_req,
	output mmu_flags_t flags
);

	logic accept;
	logic pending;
	logic decide;
	logic direct_hold;
	logic direct_req;
	logic paged;
	logic miss;
	logic data_taken;

	// Only one request in flight, so the lock is just the pending flag
	assign accept = logic_req && !pending;
	assign logic_lock = pending;

	// Paging off never touches the TLB
	assign tlb_lookup = accept && (logic_cmd.mode != PAGING_OFF);
	assign tlb_vpn = page_number(logic_cmd.addr);

	// TLB result is valid in the decide cycle
	assign paged = held_cmd.mode != PAGING_OFF;
	assign miss = paged && !tlb_hit;
	assign walk_start = decide && miss;

	// Pass-through or hit goes straight out and holds while locked
	assign direct_req = (decide && !miss) || direct_hold;
	assign mem_req = direct_req || walk_table_req || walk_access;

	// Table reads do not finish the request
	assign data_taken = mem_req && !mem_lock && !walk_table_req;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= 1'b0;
			decide <= 1'b0;
			direct_hold <= 1'b0;
		end else begin
			decide <= accept;
			direct_hold <= direct_req && mem_lock;
			if (accept) begin
				pending <= 1'b1;
			end else if (data_taken) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			held_cmd <= logic_cmd;
		end
	end

	// Command select
	always_comb begin
		mem_cmd.data_store_ack = held_cmd.data_store_ack;
		mem_cmd.mmu_use = 1'b0;
		mem_cmd.order = held_cmd.order;
		mem_cmd.mask = held_cmd.mask;
		mem_cmd.rw = held_cmd.rw;
		mem_cmd.addr = held_cmd.addr;
		mem_cmd.data = held_cmd.data;
		if (walk_table_req) begin
			// Table entry read on behalf of the walk
			mem_cmd.data_store_ack = 1'b0;
			mem_cmd.mmu_use = 1'b1;
			mem_cmd.order = TABLE_READ_ORDER;
			mem_cmd.mask = 4'h0;
			mem_cmd.rw = 1'b0;
			mem_cmd.addr = walk_table_addr;
			mem_cmd.data = '0;
		end else if (walk_access) begin
			mem_cmd.addr = walk_paddr;
		end else if (paged) begin
			// TLB hit
			mem_cmd.addr = page_addr(tlb_frame, held_cmd.addr);
		end
	end

	// Flags go out with the translated access only
	assign flags_req = walk_access || (direct_req && paged);
	assign flags = walk_access ? walk_flags : tlb_flags;

endmodule

/* hdl/mmu_walk_ctrl.sv */
module mmu_walk_ctrl
	import mmu_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic walk_start,
	input logic_cmd_t held_cmd,
	input logic mem_lock,
	input logic mem_valid,
	input word_t mem_rdata,
	output logic walk_table_req,
	output word_t walk_table_addr,
	output logic walk_access,
	output word_t walk_paddr,
	output mmu_flags_t walk_flags,
	output logic tlb_refill,
	output vpn_t tlb_refill_frame,
	output mmu_flags_t tlb_refill_flags
);

	walk_state_e state;
	walk_state_e state_next;
	logic two_level;
	logic [DIR_INDEX_BITS-1:0] dir_index;
	logic [PAGE_INDEX_BITS-1:0] page_index;
	vpn_t dir_base;
	pte_flags_t dir_flags;
	pte_flags_t upper_flags;
	vpn_t page_frame;
	pte_flags_t page_flags;

	function automatic word_t entry_addr(input word_t base, input word_t index);
		return base + index * PTE_BYTES;
	endfunction

	assign two_level = held_cmd.mode == PAGING_LEVEL_2;
	assign dir_index = held_cmd.addr[WORD_BITS-1 -: DIR_INDEX_BITS];
	assign page_index = held_cmd.addr[PAGE_OFFSET_BITS +: PAGE_INDEX_BITS];
	assign upper_flags = two_level ? dir_flags : '0;

	always_comb begin
		state_next = state;
		case (state)
			WALK_IDLE: begin
				if (walk_start) begin
					state_next = two_level ? WALK_DIR_REQ : WALK_PAGE_REQ;
				end
			end
			WALK_DIR_REQ: begin
				if (!mem_lock) begin
					state_next = WALK_DIR_WAIT;
				end
			end
			WALK_DIR_WAIT: begin
				if (mem_valid) begin
					state_next = WALK_PAGE_REQ;
				end
			end
			WALK_PAGE_REQ: begin
				if (!mem_lock) begin
					state_next = WALK_PAGE_WAIT;
				end
			end
			WALK_PAGE_WAIT: begin
				if (mem_valid) begin
					state_next = WALK_ACCESS;
				end
			end
			WALK_ACCESS: begin
				// Done once memory takes the data access
				if (!mem_lock) begin
					state_next = WALK_IDLE;
				end
			end
			default: begin
				state_next = WALK_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= WALK_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Table addresses
	always_comb begin
		if (state == WALK_DIR_REQ) begin
			walk_table_addr = entry_addr(held_cmd.pdt, word_t'(dir_index));
		end else if (two_level) begin
			walk_table_addr = entry_addr({dir_base, PAGE_OFFSET_BITS'(0)}, word_t'(page_index));
		end else begin
			// Single flat table indexed by the whole VPN
			walk_table_addr = entry_addr(held_cmd.pdt, word_t'(page_number(held_cmd.addr)));
		end
	end

	// Entry capture
	always_ff @(posedge iCLOCK) begin
		if (state == WALK_DIR_WAIT && mem_valid) begin
			dir_base <= page_number(mem_rdata);
			dir_flags <= pte_flags(mem_rdata);
		end
		if (tlb_refill) begin
			page_frame <= tlb_refill_frame;
			page_flags <= pte_flags(mem_rdata);
		end
	end

	assign walk_table_req = (state == WALK_DIR_REQ) || (state == WALK_PAGE_REQ);
	assign walk_access = state == WALK_ACCESS;
	assign walk_paddr = page_addr(page_frame, held_cmd.addr);
	assign walk_flags = '{dir: upper_flags, page: page_flags};

	// Refill straight from the final entry as it arrives
	assign tlb_refill = (state == WALK_PAGE_WAIT) && mem_valid;
	assign tlb_refill_frame = page_number(mem_rdata);
	assign tlb_refill_flags = '{dir: upper_flags, page: pte_flags(mem_rdata)};

endmodule

/* hdl/mmu_tlb.sv */
module mmu_tlb
	import mmu_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic lookup,
	input vpn_t lookup_vpn,
	input mmu_mode_e lookup_mode,
	input logic refill,
	input vpn_t refill_vpn,
	input mmu_mode_e refill_mode,
	input vpn_t refill_frame,
	input mmu_flags_t refill_flags,
	output logic hit,
	output vpn_t frame,
	output mmu_flags_t flags
);

	// Mode is part of the tag so one- and two-level entries stay apart
	typedef struct packed {
		mmu_mode_e mode;
		logic [TLB_TAG_BITS-1:0] vpn_hi;
	} tlb_tag_t;

	logic [TLB_ENTRIES-1:0] valid;
	tlb_tag_t tag_mem [TLB_ENTRIES];
	vpn_t frame_mem [TLB_ENTRIES];
	mmu_flags_t flags_mem [TLB_ENTRIES];

	logic [TLB_INDEX_BITS-1:0] lookup_index;
	logic [TLB_INDEX_BITS-1:0] refill_index;
	tlb_tag_t lookup_tag;
	tlb_tag_t refill_tag;

	assign lookup_index = lookup_vpn[TLB_INDEX_BITS-1:0];
	assign refill_index = refill_vpn[TLB_INDEX_BITS-1:0];
	assign lookup_tag = '{mode: lookup_mode, vpn_hi: lookup_vpn[VPN_BITS-1:TLB_INDEX_BITS]};
	assign refill_tag = '{mode: refill_mode, vpn_hi: refill_vpn[VPN_BITS-1:TLB_INDEX_BITS]};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= '0;
			hit <= 1'b0;
		end else begin
			// Flush wins over a refill in the same cycle
			if (flush) begin
				valid <= '0;
			end else if (refill) begin
				valid[refill_index] <= 1'b1;
			end
			if (lookup) begin
				hit <= valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (refill) begin
			tag_mem[refill_index] <= refill_tag;
			frame_mem[refill_index] <= refill_frame;
			flags_mem[refill_index] <= refill_flags;
		end
	end

	// Result held until the next lookup
	always_ff @(posedge iCLOCK) begin
		if (lookup) begin
			frame <= frame_mem[lookup_index];
			flags <= flags_mem[lookup_index];
		end
	end

endmodule

/* hdl/mmu_pkg.sv */
package mmu_pkg;

	localparam int WORD_BITS = 32;
	localparam int PAGE_OFFSET_BITS = 12;
	localparam int VPN_BITS = WORD_BITS - PAGE_OFFSET_BITS;
	localparam int DIR_INDEX_BITS = 10;
	// Page table index sits below the directory index
	localparam int PAGE_INDEX_BITS = VPN_BITS - DIR_INDEX_BITS;
	localparam int unsigned PTE_BYTES = 4;
	localparam int TLB_INDEX_BITS = 3;
	localparam int TLB_ENTRIES = 1 << TLB_INDEX_BITS;
	localparam int TLB_TAG_BITS = VPN_BITS - TLB_INDEX_BITS;
	// Word order used for every table read
	localparam logic [1:0] TABLE_READ_ORDER = 2'd2;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [VPN_BITS-1:0] vpn_t;
	typedef logic [PAGE_OFFSET_BITS-1:0] pte_flags_t;

	// Directory flags stay zero for one-level walks
	typedef struct packed {
		pte_flags_t dir;
		pte_flags_t page;
	} mmu_flags_t;

	typedef enum logic [1:0] {
		PAGING_OFF = 2'd0,
		PAGING_LEVEL_1 = 2'd1,
		PAGING_LEVEL_2 = 2'd2
	} mmu_mode_e;

	typedef enum logic [2:0] {
		WALK_IDLE = 3'd0,
		WALK_DIR_REQ = 3'd1,
		WALK_DIR_WAIT = 3'd2,
		WALK_PAGE_REQ = 3'd3,
		WALK_PAGE_WAIT = 3'd4,
		WALK_ACCESS = 3'd5
	} walk_state_e;

	typedef struct packed {
		logic data_store_ack;
		logic [1:0] order;
		logic [3:0] mask;
		logic rw;
		mmu_mode_e mode;
		word_t pdt;
		word_t addr;
		word_t data;
	} logic_cmd_t;

	typedef struct packed {
		logic data_store_ack;
		logic mmu_use;
		logic [1:0] order;
		logic [3:0] mask;
		logic rw;
		word_t addr;
		word_t data;
	} mem_cmd_t;

	// VPN of an address or base of an entry from the upper 20 bits
	function automatic vpn_t page_number(input word_t word);
		return word[WORD_BITS-1:PAGE_OFFSET_BITS];
	endfunction

	function automatic pte_flags_t pte_flags(input word_t entry);
		return entry[PAGE_OFFSET_BITS-1:0];
	endfunction

	// Physical address from a frame and the logical page offset
	function automatic word_t page_addr(input vpn_t frame, input word_t laddr);
		return {frame, laddr[PAGE_OFFSET_BITS-1:0]};
	endfunction

endpackage
